// ==== hw/simt_cfg_pkg.sv ====
package simt_cfg_pkg;

    parameter int NUM_THREADS = 4;   // threads per warp
    parameter int NUM_WARPS   = 4;
    parameter int NUM_REGS    = 32;  // registers per warp
    parameter int XLEN        = 32;

    // index widths follow the sizes above
    typedef logic [$clog2(NUM_WARPS)-1:0] wid_t;
    typedef logic [$clog2(NUM_REGS)-1:0]  reg_t;
    typedef logic [NUM_THREADS-1:0]       tmask_t;
    typedef logic [XLEN-1:0]              word_t;

endpackage

// ==== hw/simt_pipe_pkg.sv ====
package simt_pipe_pkg;

    import simt_cfg_pkg::*;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        XOR = 3'd3,
        SLL = 3'd4,  // shift by rs2[4:0]
        LDI = 3'd5,  // imm plus thread index
        MUL = 3'd6   // goes to the multiplier
    } alu_op_e;

    typedef struct packed {
        wid_t    wid;
        tmask_t  tmask;
        alu_op_e op;
        reg_t    rd;
        reg_t    rs1;
        reg_t    rs2;
        word_t   imm;
    } issue_t;

    // issued instruction plus its source operands, one word per thread
    typedef struct packed {
        issue_t                  inst;
        word_t [NUM_THREADS-1:0] rs1_data;
        word_t [NUM_THREADS-1:0] rs2_data;
    } operand_t;

    typedef struct packed {
        wid_t                    wid;
        tmask_t                  tmask;
        reg_t                    rd;
        word_t [NUM_THREADS-1:0] data;
    } wb_t;

endpackage

// ==== hw/gpr_dp_ram.sv ====
`timescale 1ns/10ps

module gpr_dp_ram #(
    parameter int SIZE = 128
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     write,
    input  logic [$clog2(SIZE)-1:0]  waddr,
    input  simt_cfg_pkg::word_t      wdata,
    input  logic [$clog2(SIZE)-1:0]  raddr,
    output simt_cfg_pkg::word_t      rdata
);

    import simt_cfg_pkg::*;

    word_t            mem [SIZE];
    logic [SIZE-1:0]  written;  // entries never written since reset read as zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            written <= '0;
        end else if (write) begin
            written[waddr] <= 1'b1;
        end
    end

    // registered read, a same-edge write is not seen
    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
        rdata <= written[raddr] ? mem[raddr] : '0;
    end

endmodule

// ==== hw/gpr_stage.sv ====
`timescale 1ns/10ps

module gpr_stage (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   wb_valid,
    input  simt_pipe_pkg::wb_t                                     wb,
    input  simt_cfg_pkg::wid_t                                     rd_wid,
    input  simt_cfg_pkg::reg_t                                     rs1,
    input  simt_cfg_pkg::reg_t                                     rs2,
    output simt_cfg_pkg::word_t [simt_cfg_pkg::NUM_THREADS-1:0]    rs1_data,
    output simt_cfg_pkg::word_t [simt_cfg_pkg::NUM_THREADS-1:0]    rs2_data
);

    import simt_cfg_pkg::*;

    localparam int RAM_SIZE  = NUM_WARPS * NUM_REGS;
    localparam int RAM_ADDRW = $clog2(RAM_SIZE);

    logic                   wr_en;
    logic [NUM_THREADS-1:0] write;
    logic [RAM_ADDRW-1:0]   waddr;
    logic [RAM_ADDRW-1:0]   raddr1;
    logic [RAM_ADDRW-1:0]   raddr2;

    assign wr_en = wb_valid && (wb.rd != '0);  // r0 stays zero

    // each warp owns its own block of NUM_REGS entries
    assign waddr  = {wb.wid, wb.rd};
    assign raddr1 = {rd_wid, rs1};
    assign raddr2 = {rd_wid, rs2};

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_thread
        assign write[i] = wr_en && wb.tmask[i];

        gpr_dp_ram #(
            .SIZE  (RAM_SIZE)
        ) rs1_ram_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .write (write[i]),
            .waddr (waddr),
            .wdata (wb.data[i]),
            .raddr (raddr1),
            .rdata (rs1_data[i])
        );

        gpr_dp_ram #(
            .SIZE  (RAM_SIZE)
        ) rs2_ram_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .write (write[i]),
            .waddr (waddr),
            .wdata (wb.data[i]),
            .raddr (raddr2),
            .rdata (rs2_data[i])
        );
    end

endmodule

// ==== hw/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  simt_pipe_pkg::operand_t in,
    input  logic                    grant,
    output logic                    out_valid,
    output simt_pipe_pkg::wb_t      out
);

    import simt_cfg_pkg::*;
    import simt_pipe_pkg::*;

    wb_t  result;
    wb_t  hold_q;
    logic hold_vld;

    always_comb begin
        result.wid   = in.inst.wid;
        result.tmask = in.inst.tmask;
        result.rd    = in.inst.rd;
        for (int t = 0; t < NUM_THREADS; t++) begin
            case (in.inst.op)
                ADD: begin
                    result.data[t] = in.rs1_data[t] + in.rs2_data[t];
                end
                SUB: begin
                    result.data[t] = in.rs1_data[t] - in.rs2_data[t];
                end
                AND: begin
                    result.data[t] = in.rs1_data[t] & in.rs2_data[t];
                end
                XOR: begin
                    result.data[t] = in.rs1_data[t] ^ in.rs2_data[t];
                end
                SLL: begin
                    result.data[t] = in.rs1_data[t] << in.rs2_data[t][4:0];
                end
                LDI: begin
                    result.data[t] = in.inst.imm + word_t'(t);  // per-thread index
                end
                default: begin
                    result.data[t] = '0;  // MUL never steered here
                end
            endcase
        end
    end

    // a new result can only land once the previous one is granted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
        end else if (in_valid) begin
            hold_vld <= 1'b1;
        end else if (grant) begin
            hold_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            hold_q <= result;
        end
    end

    assign out_valid = hold_vld;
    assign out       = hold_q;

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit #(
    parameter int LATENCY = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  simt_pipe_pkg::operand_t in,
    input  logic                    grant,
    output logic                    out_valid,
    output simt_pipe_pkg::wb_t      out
);

    import simt_cfg_pkg::*;
    import simt_pipe_pkg::*;

    wb_t                prod;
    wb_t                stage_q [LATENCY];
    logic [LATENCY-1:0] stage_vld;
    logic               stall;

    // low XLEN bits of each thread's product
    always_comb begin
        prod.wid   = in.inst.wid;
        prod.tmask = in.inst.tmask;
        prod.rd    = in.inst.rd;
        for (int t = 0; t < NUM_THREADS; t++) begin
            prod.data[t] = in.rs1_data[t] * in.rs2_data[t];
        end
    end

    assign stall = stage_vld[LATENCY-1] && !grant;  // last stage not yet written back

    // whole pipe freezes on a stall, an empty input stage still takes a new op
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_vld <= '0;
        end else if (!stall) begin
            stage_vld[0] <= in_valid;
            for (int s = 1; s < LATENCY; s++) begin
                stage_vld[s] <= stage_vld[s-1];
            end
        end else if (!stage_vld[0]) begin
            stage_vld[0] <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall || !stage_vld[0]) begin
            stage_q[0] <= prod;
        end
        if (!stall) begin
            for (int s = 1; s < LATENCY; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    assign out_valid = stage_vld[LATENCY-1];
    assign out       = stage_q[LATENCY-1];

endmodule

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/10ps

module wb_arbiter #(
    parameter int NUM_REQS = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [NUM_REQS-1:0]                 req,
    input  simt_pipe_pkg::wb_t [NUM_REQS-1:0]   req_data,
    output logic [NUM_REQS-1:0]                 grant,
    output logic                                wb_valid,
    output simt_pipe_pkg::wb_t                  wb
);

    localparam int IDXW = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;

    logic [IDXW-1:0] prio_q;   // requester with highest priority this cycle
    logic [IDXW-1:0] win_idx;
    logic            win_found;

    // first active request at or after the pointer, wrapping around
    always_comb begin
        win_found = 1'b0;
        win_idx   = prio_q;
        for (int k = 0; k < NUM_REQS; k++) begin
            if (!win_found && req[(int'(prio_q) + k) % NUM_REQS]) begin
                win_found = 1'b1;
                win_idx   = IDXW'((int'(prio_q) + k) % NUM_REQS);
            end
        end
    end

    always_comb begin
        grant          = '0;
        grant[win_idx] = win_found;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_q <= '0;
        end else if (win_found) begin
            prio_q <= (win_idx == IDXW'(NUM_REQS - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    assign wb_valid = win_found;
    assign wb       = req_data[win_idx];

endmodule

// ==== hw/simt_backend.sv ====
`timescale 1ns/10ps

module simt_backend #(
    parameter int LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  simt_pipe_pkg::issue_t  issue,
    output logic                   issue_ready,
    output logic                   wb_valid,
    output simt_pipe_pkg::wb_t     wb
);

    import simt_cfg_pkg::*;
    import simt_pipe_pkg::*;

    localparam int NUM_UNITS = 2;  // bit 0 alu, bit 1 mul

    logic                    accept;
    logic                    op_valid_q;
    issue_t                  op_inst_q;
    word_t [NUM_THREADS-1:0] rs1_data;
    word_t [NUM_THREADS-1:0] rs2_data;
    operand_t                op_data;
    logic                    is_mul;
    logic                    alu_in_valid, mul_in_valid;
    logic                    alu_out_valid, mul_out_valid;
    wb_t                     alu_out, mul_out;
    logic [NUM_UNITS-1:0]    grant;

    // operand stage empty and no result left waiting, so the
    // next dispatch always finds its unit's input free
    assign issue_ready = !op_valid_q
                      && !(alu_out_valid && !grant[0])
                      && !(mul_out_valid && !grant[1]);
    assign accept = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid_q <= 1'b0;
        end else begin
            op_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_inst_q <= issue;
        end
    end

    gpr_stage gpr_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_valid (wb_valid),
        .wb       (wb),
        .rd_wid   (issue.wid),
        .rs1      (issue.rs1),
        .rs2      (issue.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign op_data = '{inst: op_inst_q, rs1_data: rs1_data, rs2_data: rs2_data};

    assign is_mul       = (op_inst_q.op == MUL);
    assign alu_in_valid = op_valid_q && !is_mul;
    assign mul_in_valid = op_valid_q && is_mul;

    alu_unit alu_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (alu_in_valid),
        .in        (op_data),
        .grant     (grant[0]),
        .out_valid (alu_out_valid),
        .out       (alu_out)
    );

    mul_unit #(
        .LATENCY   (LATENCY)
    ) mul_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mul_in_valid),
        .in        (op_data),
        .grant     (grant[1]),
        .out_valid (mul_out_valid),
        .out       (mul_out)
    );

    wb_arbiter #(
        .NUM_REQS (NUM_UNITS)
    ) wb_arbiter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      ({mul_out_valid, alu_out_valid}),
        .req_data ({mul_out, alu_out}),
        .grant    (grant),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

// ==== tests/simt_backend_ref.svh ====
`ifndef SIMT_BACKEND_REF_SVH
`define SIMT_BACKEND_REF_SVH

word_t shadow [NUM_WARPS][NUM_REGS][NUM_THREADS];  // model register file

function automatic void shadow_clear();
    foreach (shadow[w, r, t]) begin
        shadow[w][r][t] = '0;
    end
endfunction

// one thread's result, taken from the op definitions
function automatic word_t ref_result(alu_op_e op, word_t a, word_t b, word_t imm, int t);
    logic [2*XLEN-1:0] wide;
    wide = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
        ADD:     return a + b;
        SUB:     return a - b;
        AND:     return a & b;
        XOR:     return a ^ b;
        SLL:     return a << b[4:0];
        LDI:     return imm + word_t'(t);
        MUL:     return wide[XLEN-1:0];  // low half of the full product
        default: return '0;
    endcase
endfunction

function automatic wb_t ref_expect(issue_t inst);
    wb_t w;
    w.wid   = inst.wid;
    w.tmask = inst.tmask;
    w.rd    = inst.rd;
    for (int t = 0; t < NUM_THREADS; t++) begin
        w.data[t] = ref_result(inst.op, shadow[inst.wid][inst.rs1][t],
                               shadow[inst.wid][inst.rs2][t], inst.imm, t);
    end
    return w;
endfunction

// r0 and threads outside the mask keep their value
function automatic void shadow_commit(wb_t w);
    for (int t = 0; t < NUM_THREADS; t++) begin
        if (w.rd != '0 && w.tmask[t]) begin
            shadow[w.wid][w.rd][t] = w.data[t];
        end
    end
endfunction

`endif

// ==== tests/simt_backend_tb.sv ====
`timescale 1ns/10ps

module simt_backend_tb;

    import simt_cfg_pkg::*;
    import simt_pipe_pkg::*;

    localparam int LATENCY = 3;
    localparam int TIMEOUT = 40;  // cycles allowed for any one wait

    logic   clk;
    logic   rst_n;
    logic   issue_valid;
    issue_t issue;
    logic   issue_ready;
    logic   wb_valid;
    wb_t    wb;

    wb_t         pending [$];  // expected results not yet committed
    wb_t         commits [$];  // observed commits not yet checked
    logic [31:0] rng_state = 32'h13670020;
    string       test_name;
    int          test_errs;
    int          num_passed;
    int          num_failed;
    logic        hung;

    `include "simt_backend_ref.svh"

    simt_backend #(
        .LATENCY     (LATENCY)
    ) simt_backend_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            commits.push_back(wb);
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic issue_t make_inst(wid_t wid, tmask_t tmask, alu_op_e op,
                                         reg_t rd, reg_t rs1, reg_t rs2, word_t imm);
        issue_t i;
        i.wid   = wid;
        i.tmask = tmask;
        i.op    = op;
        i.rd    = rd;
        i.rs1   = rs1;
        i.rs2   = rs2;
        i.imm   = imm;
        return i;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0 && !hung) begin
            num_passed++;
            $display("test %s: ok", test_name);
        end else begin
            num_failed++;
            $display("test %s: FAILED with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic check_idle();
        assert (wb_valid === 1'b0) else begin
            $display("** Error %s: wb_valid expected 0, actual %b", test_name, wb_valid);
            test_errs++;
        end
        assert (issue_ready === 1'b1) else begin
            $display("** Error %s: issue_ready expected 1, actual %b", test_name, issue_ready);
            test_errs++;
        end
    endtask

    // entered just after a rising edge, returns just after the accepting edge
    task automatic send(input issue_t inst);
        int waited;
        if (!hung) begin
            pending.push_back(ref_expect(inst));
            issue_valid <= 1'b1;
            issue       <= inst;
            waited = 0;
            @(negedge clk);
            while (!issue_ready && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!issue_ready) begin
                $display("%s: issue_ready stayed low for %0d cycles", test_name, TIMEOUT);
                test_errs++;
                hung = 1'b1;
            end
            @(posedge clk);
            issue_valid <= 1'b0;
        end
    endtask

    // match every outstanding result against the commits, in any order
    task automatic drain();
        wb_t got;
        int  idx;
        int  waited;
        while (pending.size() > 0 && !hung) begin
            waited = 0;
            while (commits.size() == 0 && waited < TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (commits.size() == 0) begin
                $display("%s: no commit within %0d cycles", test_name, TIMEOUT);
                test_errs++;
                hung = 1'b1;
            end else begin
                got = commits.pop_front();
                idx = -1;
                foreach (pending[i]) begin
                    if (idx < 0 && pending[i].wid == got.wid && pending[i].rd == got.rd) begin
                        idx = i;
                    end
                end
                assert (idx >= 0) else begin
                    $display("%s: commit to warp %0d r%0d matches no issued instruction",
                             test_name, got.wid, got.rd);
                    test_errs++;
                end
                if (idx >= 0) begin
                    assert (got.tmask == pending[idx].tmask) else begin
                        $display("** Error %s: tmask expected %h, actual %h",
                                 test_name, pending[idx].tmask, got.tmask);
                        test_errs++;
                    end
                    for (int t = 0; t < NUM_THREADS; t++) begin
                        assert (got.data[t] === pending[idx].data[t]) else begin
                            $display("** Error %s: r%0d thread %0d expected %h, actual %h",
                                     test_name, got.rd, t, pending[idx].data[t], got.data[t]);
                            test_errs++;
                        end
                    end
                    shadow_commit(pending[idx]);
                    pending.delete(idx);
                end
            end
        end
        repeat (LATENCY + 4) @(posedge clk);  // a second commit would land here
        assert (commits.size() == 0) else begin
            $display("%s: %0d commits beyond the issued instructions", test_name, commits.size());
            test_errs++;
        end
        commits.delete();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        hung        = 1'b0;
        num_passed  = 0;
        num_failed  = 0;
        shadow_clear();

        start_test("reset_state");
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check_idle();
        end
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        for (int w = 0; w < NUM_WARPS; w++) begin
            send(make_inst(wid_t'(w), 4'hf, ADD, 5'd5, 5'd5, 5'd0, '0));
            drain();
        end
        finish_test();

        start_test("masked_load");
        send(make_inst(2'd1, 4'hf, LDI, 5'd7, 5'd0, 5'd0, next_rand()));
        drain();
        send(make_inst(2'd1, 4'b0101, LDI, 5'd7, 5'd0, 5'd0, next_rand()));
        drain();
        send(make_inst(2'd1, 4'hf, ADD, 5'd8, 5'd7, 5'd0, '0));
        drain();
        finish_test();

        start_test("r0_guard");
        send(make_inst(2'd2, 4'hf, LDI, 5'd0, 5'd0, 5'd0, next_rand()));
        drain();
        send(make_inst(2'd2, 4'hf, ADD, 5'd9, 5'd0, 5'd0, '0));
        drain();
        finish_test();

        start_test("warp_isolation");
        send(make_inst(2'd0, 4'hf, LDI, 5'd10, 5'd0, 5'd0, next_rand()));
        send(make_inst(2'd3, 4'hf, LDI, 5'd10, 5'd0, 5'd0, next_rand()));
        drain();
        send(make_inst(2'd0, 4'hf, ADD, 5'd11, 5'd10, 5'd0, '0));
        send(make_inst(2'd3, 4'hf, ADD, 5'd11, 5'd10, 5'd0, '0));
        drain();
        finish_test();

        start_test("alu_ops");
        for (int n = 0; n < 3; n++) begin
            send(make_inst(2'd2, 4'hf, LDI, 5'd12, 5'd0, 5'd0, next_rand()));
            send(make_inst(2'd2, 4'hf, LDI, 5'd13, 5'd0, 5'd0, next_rand()));
            drain();
            send(make_inst(2'd2, 4'hf, ADD, 5'd14, 5'd12, 5'd13, '0));
            send(make_inst(2'd2, 4'hf, SUB, 5'd15, 5'd12, 5'd13, '0));
            send(make_inst(2'd2, 4'hf, AND, 5'd16, 5'd12, 5'd13, '0));
            send(make_inst(2'd2, 4'hf, XOR, 5'd17, 5'd12, 5'd13, '0));
            send(make_inst(2'd2, 4'hf, SLL, 5'd18, 5'd12, 5'd13, '0));
            drain();
        end
        finish_test();

        // the first clash lets the multiplier win, the later one makes it stall
        start_test("contention");
        send(make_inst(2'd1, 4'hf, LDI, 5'd20, 5'd0, 5'd0, next_rand()));
        send(make_inst(2'd1, 4'hf, LDI, 5'd21, 5'd0, 5'd0, next_rand()));
        drain();
        send(make_inst(2'd1, 4'hf, MUL, 5'd22, 5'd20, 5'd21, '0));
        send(make_inst(2'd1, 4'hf, ADD, 5'd23, 5'd20, 5'd21, '0));
        send(make_inst(2'd1, 4'b1011, MUL, 5'd24, 5'd21, 5'd21, '0));
        send(make_inst(2'd1, 4'hf, MUL, 5'd28, 5'd20, 5'd20, '0));
        send(make_inst(2'd1, 4'hf, SUB, 5'd25, 5'd20, 5'd21, '0));
        send(make_inst(2'd1, 4'hf, XOR, 5'd26, 5'd20, 5'd21, '0));
        send(make_inst(2'd1, 4'hf, AND, 5'd27, 5'd20, 5'd21, '0));
        drain();
        finish_test();

        $display("summary: %0d tests run, %0d passed, %0d failed",
                 num_passed + num_failed, num_passed, num_failed);
        if (num_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== simt_backend.f ====
+incdir+tests
hw/simt_cfg_pkg.sv
hw/simt_pipe_pkg.sv
hw/gpr_dp_ram.sv
hw/gpr_stage.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/wb_arbiter.sv
hw/simt_backend.sv
tests/simt_backend_tb.sv
